// ==== io_map_pkg.sv ====
package io_map_pkg;

  // --------------------------------------------------------------------------
  // Indexed register port pair
  // --------------------------------------------------------------------------

  // Register number select
  localparam logic [15:0] REG_ADDR_PORT = 16'hFC3B;
  // Register contents
  localparam logic [15:0] REG_DATA_PORT = 16'hFD3B;

  // --------------------------------------------------------------------------
  // Register numbers behind the data port
  // --------------------------------------------------------------------------

  // Device enable bits
  localparam logic [7:0] REG_DEVOPTIONS = 8'h0E;
  // Free byte for software
  localparam logic [7:0] REG_SCRATCH    = 8'hFE;
  // Core identification, one char per read
  localparam logic [7:0] REG_COREID     = 8'hFF;

  // --------------------------------------------------------------------------
  // Fixed bus values
  // --------------------------------------------------------------------------

  // Seen by the Z80 during a maskable interrupt acknowledge
  localparam logic [7:0] INTACK_VALUE = 8'hFF;
  // Pulled-up bus, nobody drives it
  localparam logic [7:0] FLOAT_VALUE  = 8'hFF;

  // --------------------------------------------------------------------------
  // Core ID string
  // --------------------------------------------------------------------------

  localparam int COREID_LEN = 4;
  // First char in the top byte
  localparam logic [COREID_LEN*8-1:0] COREID_STR = "IO01";
  // Index counts up to COREID_LEN, which points at the zero terminator
  localparam int COREID_IDX_W = $clog2(COREID_LEN + 1);

endpackage

// ==== bus_pkg.sv ====
package bus_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  // Z80 pins as seen by the core, strobes active low
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] dout;
    logic              iorq_n;
    logic              rd_n;
    logic              wr_n;
    logic              m1_n;
  } z80_bus_t;

  // One I/O access, strobe lasts a single cycle
  typedef struct packed {
    logic              strobe;
    logic              is_read;
    logic              is_intack;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } io_access_t;

  // Data port access towards the register bank
  typedef struct packed {
    logic              strobe;
    logic              is_read;
    logic [DATA_W-1:0] regnum;
    logic [DATA_W-1:0] data;
    // New value written to the address port
    logic              addr_changed;
  } reg_req_t;

  // Read data heading for the CPU
  typedef struct packed {
    logic              valid;
    logic              is_intack;
    logic [DATA_W-1:0] data;
  } rd_resp_t;

  // Device options register, bit 0 at the bottom
  typedef struct packed {
    logic disable_spisd;
    logic enable_timexmmu;
    logic disable_romsel1f;
    logic disable_romsel7f;
    logic disable_1ffd;
    logic disable_7ffd;
    logic disable_turboay;
    logic disable_ay;
  } dev_options_t;

endpackage

// ==== bus_sample.sv ====
`timescale 1ns/100ps

module bus_sample (
  input  logic                sysclk,
  input  logic                arst_n,
  input  bus_pkg::z80_bus_t   bus,
  output bus_pkg::io_access_t access
);
  import bus_pkg::*;

  z80_bus_t          bus_q;
  logic              armed;
  logic              io_cycle;
  logic              start;
  logic              strobe_q;
  logic              is_read_q;
  logic              is_intack_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] data_q;

  // Plain sample of the pins every edge
  always_ff @(posedge sysclk) begin
    bus_q <= bus;
  end

  // Read, write or interrupt acknowledge in progress
  assign io_cycle = !bus_q.iorq_n && (!bus_q.rd_n || !bus_q.wr_n || !bus_q.m1_n);
  assign start    = armed && io_cycle;

  // Armed while iorq_n idles high, spent by the first start
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      armed <= 1'b0;
    end else if (bus_q.iorq_n) begin
      armed <= 1'b1;
    end else if (start) begin
      armed <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------------
  // Access strobe, one cycle per I/O cycle
  // ----------------------------------------------------------------------------

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      strobe_q    <= 1'b0;
      is_read_q   <= 1'b0;
      is_intack_q <= 1'b0;
    end else begin
      strobe_q    <= start;
      // m1_n low with iorq_n means acknowledge, never a port read
      is_read_q   <= start && !bus_q.rd_n && bus_q.m1_n;
      is_intack_q <= start && !bus_q.m1_n;
    end
  end

  // Address and write data, held until the next start
  always_ff @(posedge sysclk) begin
    if (start) begin
      addr_q <= bus_q.addr;
      data_q <= bus_q.dout;
    end
  end

  assign access = '{strobe: strobe_q, is_read: is_read_q, is_intack: is_intack_q,
                    addr: addr_q, data: data_q};

  // Back to back strobes would mean a lost iorq_n edge
  a_single_strobe: assert property (@(posedge sysclk) disable iff (!arst_n)
    access.strobe |=> !access.strobe);

endmodule

// ==== port_decode.sv ====
`timescale 1ns/100ps

module port_decode (
  input  logic                sysclk,
  input  logic                arst_n,
  input  bus_pkg::io_access_t access,
  output bus_pkg::reg_req_t   req,
  output bus_pkg::rd_resp_t   resp
);
  import bus_pkg::*;
  import io_map_pkg::*;

  logic [DATA_W-1:0] regaddr_q;
  logic              at_addr_port;
  logic              at_data_port;
  logic              is_write;
  logic              addr_wr;
  logic              data_acc;
  rd_resp_t          resp_d;
  // Request stage
  logic              req_strobe_q;
  logic              req_read_q;
  logic              req_changed_q;
  logic [DATA_W-1:0] req_regnum_q;
  logic [DATA_W-1:0] req_data_q;
  // Two response stages
  logic              s1_valid;
  logic              s1_intack;
  logic [DATA_W-1:0] s1_data;
  logic              s2_valid;
  logic              s2_intack;
  logic [DATA_W-1:0] s2_data;

  // Full 16 bit compare
  assign at_addr_port = (access.addr == REG_ADDR_PORT);
  assign at_data_port = (access.addr == REG_DATA_PORT);
  assign is_write     = access.strobe && !access.is_read && !access.is_intack;
  assign addr_wr      = is_write && at_addr_port;
  assign data_acc     = access.strobe && !access.is_intack && at_data_port;

  // ----------------------------------------------------------------------------
  // Register address and bank request
  // ----------------------------------------------------------------------------

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      regaddr_q     <= '0;
      req_strobe_q  <= 1'b0;
      req_read_q    <= 1'b0;
      req_changed_q <= 1'b0;
    end else begin
      if (addr_wr) begin
        regaddr_q <= access.data;
      end
      req_strobe_q  <= data_acc;
      req_read_q    <= data_acc && access.is_read;
      // Pulses alone, no strobe alongside
      req_changed_q <= addr_wr;
    end
  end

  // Register number taken before any update
  always_ff @(posedge sysclk) begin
    if (data_acc) begin
      req_regnum_q <= regaddr_q;
      req_data_q   <= access.data;
    end
  end

  assign req = '{strobe: req_strobe_q, is_read: req_read_q, regnum: req_regnum_q,
                 data: req_data_q, addr_changed: req_changed_q};

  // ----------------------------------------------------------------------------
  // Responses answered here
  // ----------------------------------------------------------------------------

  always_comb begin
    resp_d = '{valid: 1'b0, is_intack: 1'b0, data: FLOAT_VALUE};
    if (access.strobe) begin
      // Acknowledge wins whatever the address
      if (access.is_intack) begin
        resp_d = '{valid: 1'b1, is_intack: 1'b1, data: INTACK_VALUE};
      end else if (access.is_read && at_addr_port) begin
        resp_d = '{valid: 1'b1, is_intack: 1'b0, data: regaddr_q};
      end else if (access.is_read && !at_data_port) begin
        // Unclaimed port
        resp_d = '{valid: 1'b1, is_intack: 1'b0, data: FLOAT_VALUE};
      end
    end
  end

  // Extra stage lines these up with the bank responses
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid  <= 1'b0;
      s1_intack <= 1'b0;
      s2_valid  <= 1'b0;
      s2_intack <= 1'b0;
    end else begin
      s1_valid  <= resp_d.valid;
      s1_intack <= resp_d.is_intack;
      s2_valid  <= s1_valid;
      s2_intack <= s1_intack;
    end
  end

  always_ff @(posedge sysclk) begin
    s1_data <= resp_d.data;
    s2_data <= s1_data;
  end

  assign resp = '{valid: s2_valid, is_intack: s2_intack, data: s2_data};

  // Sampler must keep acknowledge and read apart
  a_read_xor_intack: assert property (@(posedge sysclk) disable iff (!arst_n)
    access.strobe |-> !(access.is_read && access.is_intack));

endmodule

// ==== reg_bank.sv ====
`timescale 1ns/100ps

module reg_bank (
  input  logic                  sysclk,
  input  logic                  arst_n,
  input  bus_pkg::reg_req_t     req,
  output bus_pkg::rd_resp_t     resp,
  output bus_pkg::dev_options_t dev_options
);
  import bus_pkg::*;
  import io_map_pkg::*;

  logic [DATA_W-1:0]       scratch_q;
  dev_options_t            dev_options_q;
  logic [COREID_IDX_W-1:0] id_idx_q;
  logic                    rd_req;
  logic                    wr_req;
  logic                    id_rd;
  logic [DATA_W-1:0]       id_byte;
  logic [DATA_W-1:0]       rd_data;
  logic                    resp_valid_q;
  logic [DATA_W-1:0]       resp_data_q;

  assign rd_req = req.strobe && req.is_read;
  assign wr_req = req.strobe && !req.is_read;
  assign id_rd  = rd_req && (req.regnum == REG_COREID);

  // Char at the index or zero once past the end
  assign id_byte = (id_idx_q < COREID_IDX_W'(COREID_LEN)) ?
                   COREID_STR[(COREID_LEN - 1 - int'(id_idx_q)) * 8 +: 8] : '0;

  // ----------------------------------------------------------------------------
  // Read data select
  // ----------------------------------------------------------------------------

  always_comb begin
    case (req.regnum)
      REG_SCRATCH:    rd_data = scratch_q;
      REG_DEVOPTIONS: rd_data = dev_options_q;
      REG_COREID:     rd_data = id_byte;
      // Register not implemented here
      default:        rd_data = FLOAT_VALUE;
    endcase
  end

  // ----------------------------------------------------------------------------
  // Writable registers and ID index
  // ----------------------------------------------------------------------------

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      scratch_q     <= '0;
      dev_options_q <= '0;
    end else if (wr_req) begin
      case (req.regnum)
        REG_SCRATCH:    scratch_q     <= req.data;
        REG_DEVOPTIONS: dev_options_q <= dev_options_t'(req.data);
        default:        ;
      endcase
    end
  end

  // Restart the string on any address port write
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      id_idx_q <= '0;
    end else if (req.addr_changed) begin
      id_idx_q <= '0;
    end else if (id_rd && (id_idx_q < COREID_IDX_W'(COREID_LEN))) begin
      // Parks on the terminator
      id_idx_q <= id_idx_q + COREID_IDX_W'(1);
    end
  end

  // ----------------------------------------------------------------------------
  // Response
  // ----------------------------------------------------------------------------

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= rd_req;
    end
  end

  always_ff @(posedge sysclk) begin
    if (rd_req) begin
      resp_data_q <= rd_data;
    end
  end

  assign resp        = '{valid: resp_valid_q, is_intack: 1'b0, data: resp_data_q};
  assign dev_options = dev_options_q;

  // Response valid one cycle after a read and only for that cycle
  a_rd_latency: assert property (@(posedge sysclk) disable iff (!arst_n)
    rd_req |=> resp.valid ##1 !resp.valid);

endmodule

// ==== read_mux.sv ====
`timescale 1ns/100ps

module read_mux (
  input  logic                       sysclk,
  input  logic                       arst_n,
  input  bus_pkg::rd_resp_t          decode_resp,
  input  bus_pkg::rd_resp_t          bank_resp,
  output logic [bus_pkg::DATA_W-1:0] cpu_din
);
  import bus_pkg::*;
  import io_map_pkg::*;

  logic              load;
  logic [DATA_W-1:0] sel_data;

  // Fixed priority, acknowledge first
  always_comb begin
    load = decode_resp.valid || bank_resp.valid;
    if (decode_resp.valid && decode_resp.is_intack) begin
      sel_data = INTACK_VALUE;
    end else if (decode_resp.valid) begin
      sel_data = decode_resp.data;
    end else begin
      sel_data = bank_resp.data;
    end
  end

  // Held until the next response
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      cpu_din <= FLOAT_VALUE;
    end else if (load) begin
      cpu_din <= sel_data;
    end
  end

  // Decoder and bank never answer the same access
  a_one_source: assert property (@(posedge sysclk) disable iff (!arst_n)
    !(decode_resp.valid && bank_resp.valid));

endmodule

// ==== zxuno_io.sv ====
`timescale 1ns/100ps

module zxuno_io (
  input  logic                       sysclk,
  input  logic                       arst_n,
  input  bus_pkg::z80_bus_t          bus,
  output logic [bus_pkg::DATA_W-1:0] cpu_din,
  output bus_pkg::dev_options_t      dev_options
);
  import bus_pkg::*;

  io_access_t access;
  reg_req_t   req;
  // Address port, acknowledge and unclaimed reads
  rd_resp_t   decode_resp;
  // Data port reads
  rd_resp_t   bank_resp;

  bus_sample u_bus_sample (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .bus    (bus),
    .access (access)
  );

  port_decode u_port_decode (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .access (access),
    .req    (req),
    .resp   (decode_resp)
  );

  reg_bank u_reg_bank (
    .sysclk      (sysclk),
    .arst_n      (arst_n),
    .req         (req),
    .resp        (bank_resp),
    .dev_options (dev_options)
  );

  read_mux u_read_mux (
    .sysclk      (sysclk),
    .arst_n      (arst_n),
    .decode_resp (decode_resp),
    .bank_resp   (bank_resp),
    .cpu_din     (cpu_din)
  );

endmodule

// ==== tb_zxuno_io.sv ====
`timescale 1ns/100ps

module tb_zxuno_io;
  import bus_pkg::*;
  import io_map_pkg::*;

  localparam int CLK_HALF  = 4;
  localparam int RESET_CYC = 16;
  // Edges from E to the output register update
  localparam int RD_LAT    = 4;
  localparam int OPT_LAT   = 3;
  // Number of bus cycles in the sequence
  localparam int N_ACCESS  = 34;
  localparam logic [7:0] EXP_FLOAT  = 8'hFF;
  localparam logic [7:0] EXP_INTACK = 8'hFF;

  logic         sysclk;
  logic         arst_n;
  z80_bus_t     bus;
  logic [7:0]   cpu_din;
  dev_options_t dev_options;

  // Time base for the expected values
  int unsigned  edge_cnt = 0;
  logic [15:0]  lfsr_state = 16'd20344;
  logic [7:0]   rnd;
  // Model of the register file
  logic [7:0]   regaddr_m;
  logic [7:0]   scratch_m;
  // ASCII I O 0 1 and the terminator twice
  logic [7:0]   id_expect [6];
  // Expected cpu_din switches from old to new at rd_due
  logic [7:0]   rd_old;
  logic [7:0]   rd_exp;
  int unsigned  rd_due;
  logic [7:0]   rd_want;
  // Same scheme for dev_options
  dev_options_t opt_old;
  dev_options_t opt_exp;
  int unsigned  opt_due;
  dev_options_t opt_want;

  zxuno_io dut (
    .sysclk      (sysclk),
    .arst_n      (arst_n),
    .bus         (bus),
    .cpu_din     (cpu_din),
    .dev_options (dev_options)
  );

  initial begin
    sysclk = 1'b0;
    forever begin
      #CLK_HALF sysclk = ~sysclk;
    end
  end

  always @(posedge sysclk) begin
    edge_cnt <= edge_cnt + 1;
  end

  assign rd_want  = (edge_cnt >= rd_due) ? rd_exp : rd_old;
  assign opt_want = (edge_cnt >= opt_due) ? opt_exp : opt_old;

  // --------------------------------------------------------------------------
  // Checks on every edge out of reset
  // --------------------------------------------------------------------------

  // New read data exactly RD_LAT edges after E and held until the next one
  a_cpu_din: assert property (@(posedge sysclk) disable iff (!arst_n) cpu_din == rd_want)
    else begin
      $display("ERR %0t: cpu_din is %02h, expected %02h", $time, $sampled(cpu_din),
               $sampled(rd_want));
      $display("sim failed");
      $fatal(1, "read data mismatch");
    end

  // Zero after reset and each write visible exactly OPT_LAT edges after E
  a_dev_options: assert property (@(posedge sysclk) disable iff (!arst_n)
    dev_options == opt_want)
    else begin
      $display("ERR %0t: dev_options is %02h, expected %02h", $time,
               $sampled(dev_options), $sampled(opt_want));
      $display("sim failed");
      $fatal(1, "device options mismatch");
    end

  // --------------------------------------------------------------------------
  // Random bytes
  // --------------------------------------------------------------------------

  // Right shifting x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One step per bit
  task automatic random_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      b[i]       = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // --------------------------------------------------------------------------
  // Bus cycles starting on a rising edge
  // --------------------------------------------------------------------------

  // Strobes held 3 cycles and then idle so the next start sees iorq_n high
  task automatic drive_cycle(input logic [15:0] addr, input logic [7:0] data,
                             input logic rd_n, input logic wr_n, input logic m1_n);
    bus.addr   <= addr;
    bus.dout   <= data;
    bus.iorq_n <= 1'b0;
    bus.rd_n   <= rd_n;
    bus.wr_n   <= wr_n;
    bus.m1_n   <= m1_n;
    repeat (3) @(posedge sysclk);
    bus.iorq_n <= 1'b1;
    bus.rd_n   <= 1'b1;
    bus.wr_n   <= 1'b1;
    bus.m1_n   <= 1'b1;
    // Third idle edge is where the next cycle drives
    repeat (2) @(posedge sysclk);
  endtask

  // E is the next edge and the update shows in the sample one edge after E+n
  task automatic expect_read(input logic [7:0] value);
    rd_old = rd_exp;
    rd_exp = value;
    rd_due = edge_cnt + 1 + RD_LAT + 1;
  endtask

  task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
    @(posedge sysclk);
    if (addr == REG_ADDR_PORT) begin
      regaddr_m = data;
    end else if (addr == REG_DATA_PORT && regaddr_m == REG_SCRATCH) begin
      scratch_m = data;
    end else if (addr == REG_DATA_PORT && regaddr_m == REG_DEVOPTIONS) begin
      opt_old = opt_exp;
      opt_exp = dev_options_t'(data);
      opt_due = edge_cnt + 1 + OPT_LAT + 1;
    end
    drive_cycle(addr, data, 1'b1, 1'b0, 1'b1);
  endtask

  task automatic io_read(input logic [15:0] addr, input logic [7:0] value);
    @(posedge sysclk);
    expect_read(value);
    drive_cycle(addr, 8'h00, 1'b0, 1'b1, 1'b1);
  endtask

  // m1_n and iorq_n together with rd_n high
  task automatic intack_cycle(input logic [15:0] addr);
    @(posedge sysclk);
    expect_read(EXP_INTACK);
    drive_cycle(addr, 8'h00, 1'b1, 1'b1, 1'b0);
  endtask

  // --------------------------------------------------------------------------
  // Sequence
  // --------------------------------------------------------------------------

  initial begin
    arst_n    = 1'b0;
    bus       = '{addr: '0, dout: '0, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1, m1_n: 1'b1};
    regaddr_m = 8'h00;
    scratch_m = 8'h00;
    id_expect = '{8'h49, 8'h4F, 8'h30, 8'h31, 8'h00, 8'h00};
    rd_old    = EXP_FLOAT;
    rd_exp    = EXP_FLOAT;
    rd_due    = 0;
    opt_old   = '0;
    opt_exp   = '0;
    opt_due   = 0;
    repeat (RESET_CYC) @(posedge sysclk);
    arst_n <= 1'b1;
    repeat (4) @(posedge sysclk);

    // Address port loop back
    random_byte(rnd);
    io_write(REG_ADDR_PORT, rnd);
    io_read(REG_ADDR_PORT, regaddr_m);

    io_write(REG_ADDR_PORT, REG_SCRATCH);
    for (int i = 0; i < 8; i++) begin
      random_byte(rnd);
      io_write(REG_DATA_PORT, rnd);
      io_read(REG_DATA_PORT, scratch_m);
    end

    // Other cycles in between must not move the ID index
    io_write(REG_ADDR_PORT, REG_COREID);
    io_read(REG_DATA_PORT, id_expect[0]);
    // Acknowledge on the data port reads no register
    intack_cycle(REG_DATA_PORT);
    io_read(REG_DATA_PORT, id_expect[1]);
    // ULA port is not decoded here
    io_read(16'h00FE, EXP_FLOAT);
    for (int i = 2; i < 6; i++) begin
      io_read(REG_DATA_PORT, id_expect[i]);
    end
    // Reselect restarts the string
    io_write(REG_ADDR_PORT, REG_COREID);
    io_read(REG_DATA_PORT, id_expect[0]);

    // Acknowledge wins over the address port decode
    io_write(REG_ADDR_PORT, REG_DEVOPTIONS);
    intack_cycle(REG_ADDR_PORT);
    random_byte(rnd);
    io_write(REG_DATA_PORT, rnd);
    io_read(REG_DATA_PORT, opt_exp);

    // Let the last response reach the checks
    repeat (RD_LAT + 4) @(posedge sysclk);
    $display("sim passed");
    $finish;
  end

  initial begin
    #(2 * CLK_HALF * (N_ACCESS * 6 + 100));
    $display("Timeout, the test sequence did not finish within %0d cycles",
             N_ACCESS * 6 + 100);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== zxuno_io.f ====
io_map_pkg.sv
bus_pkg.sv
bus_sample.sv
port_decode.sv
reg_bank.sv
read_mux.sv
zxuno_io.sv
tb_zxuno_io.sv

// ==== Makefile ====
TOP = tb_zxuno_io

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module zxuno_io -f zxuno_io.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f zxuno_io.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
